// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path width of the core.
`define CPU_XLEN 32

// architectural register file.
`define CPU_NUM_REGS 16
`define CPU_REG_AW ($clog2(`CPU_NUM_REGS))

// fetch queue entries, which is also the number of credits the fetch unit starts with.
`define CPU_QUEUE_DEPTH 4
`define CPU_QUEUE_AW ($clog2(`CPU_QUEUE_DEPTH))

// the credit counter and the queue occupancy both range from 0 to the full depth.
`define CPU_CREDIT_W ($clog2(`CPU_QUEUE_DEPTH + 1))

// instruction memory is word addressed, so the pc is a word index.
`define CPU_IMEM_WORDS 256
`define CPU_PC_W ($clog2(`CPU_IMEM_WORDS))

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_REG_AW-1:0] reg_idx_t;
	typedef logic [`CPU_PC_W-1:0] pc_t;
	typedef logic [`CPU_CREDIT_W-1:0] credit_t;
	typedef logic [`CPU_QUEUE_AW-1:0] qptr_t;

	// encodings 12 to 15 are unused and decode as nop.
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLT  = 4'd5,
		ADDI = 4'd6,
		LUI  = 4'd7,
		BEQZ = 4'd8,
		BNEZ = 4'd9,
		HALT = 4'd10,
		NOP  = 4'd11
	} opcode_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [15:0] imm;
	} instr_t;

	// the pc travels with the instruction so that branches can form their target.
	typedef struct packed {
		instr_t instr;
		pc_t    pc;
	} fetch_pkt_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    data;
	} wb_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       run,
	input  logic       prog_we,
	input  pc_t        prog_addr,
	input  instr_t     prog_data,
	input  logic       redirect,
	input  pc_t        redirect_pc,
	input  logic       credit_return,
	output logic       push,
	output fetch_pkt_t pkt
);

	instr_t imem [`CPU_IMEM_WORDS];

	pc_t     pc;
	credit_t credits;

	// the program port is the only writer of the instruction memory.
	always_ff @(posedge CLK) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// one credit per free queue entry, so a push never finds the queue full.
	assign push = run && (credits != '0);

	assign pkt.instr = imem[pc];
	assign pkt.pc    = pc;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (push) begin
			pc <= pc + pc_t'(1);
		end
	end

	// a redirect flushes the queue, so every credit comes back at once.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			credits <= credit_t'(`CPU_QUEUE_DEPTH);
		end else if (redirect) begin
			credits <= credit_t'(`CPU_QUEUE_DEPTH);
		end else if (push && !credit_return) begin
			credits <= credits - credit_t'(1);
		end else if (!push && credit_return) begin
			credits <= credits + credit_t'(1);
		end
	end

endmodule

// ==== source/fetch_queue.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_queue import cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       push,
	input  fetch_pkt_t pkt,
	input  logic       take,
	input  logic       flush,
	output logic       head_valid,
	output fetch_pkt_t head,
	output logic       credit_return
);

	fetch_pkt_t entries [`CPU_QUEUE_DEPTH];

	qptr_t   rd_ptr;
	qptr_t   wr_ptr;
	credit_t count;
	logic    do_push;
	logic    do_take;

	// a push in the flush cycle belongs to the wrong path and is dropped.
	assign do_push = push && !flush;
	assign do_take = take && !flush;

	always_ff @(posedge CLK) begin
		if (do_push) begin
			entries[wr_ptr] <= pkt;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == qptr_t'(`CPU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + qptr_t'(1);
			end
			if (do_take) begin
				rd_ptr <= (rd_ptr == qptr_t'(`CPU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + qptr_t'(1);
			end
			case ({do_push, do_take})
				2'b10:   count <= count + credit_t'(1);
				2'b01:   count <= count - credit_t'(1);
				default: count <= count;
			endcase
		end
	end

	assign head_valid = (count != '0);
	assign head       = entries[rd_ptr];

	// the fetch unit refills its credits itself on a flush.
	assign credit_return = do_take;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module register_file import cpu_pkg::*; (
	input  logic     CLK,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    rd_data1,
	output word_t    rd_data2,
	input  logic     we,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data
);

	// r0 has no storage.
	word_t regs [1:`CPU_NUM_REGS-1];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd_data2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit import cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       hold,
	input  logic       head_valid,
	input  fetch_pkt_t head,
	output logic       take,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	input  word_t      rd_data1,
	input  word_t      rd_data2,
	output logic       we,
	output reg_idx_t   wr_addr,
	output word_t      wr_data,
	output logic       redirect,
	output pc_t        redirect_pc,
	output logic       wb_valid,
	output wb_t        wb,
	output logic       halted
);

	instr_t ins;
	word_t  imm_sext;
	word_t  result;
	logic   writes_rd;
	logic   branch_taken;
	logic   is_halt;

	assign ins      = head.instr;
	assign imm_sext = {{16{ins.imm[15]}}, ins.imm};

	assign take = head_valid && !hold && !halted;
	assign rs1  = ins.rs1;
	assign rs2  = ins.rs2;

	always_comb begin
		result       = '0;
		writes_rd    = 1'b0;
		branch_taken = 1'b0;
		is_halt      = 1'b0;
		case (ins.opcode)
			ADD: begin
				result    = rd_data1 + rd_data2;
				writes_rd = 1'b1;
			end
			SUB: begin
				result    = rd_data1 - rd_data2;
				writes_rd = 1'b1;
			end
			AND: begin
				result    = rd_data1 & rd_data2;
				writes_rd = 1'b1;
			end
			OR: begin
				result    = rd_data1 | rd_data2;
				writes_rd = 1'b1;
			end
			XOR: begin
				result    = rd_data1 ^ rd_data2;
				writes_rd = 1'b1;
			end
			SLT: begin
				result    = word_t'($signed(rd_data1) < $signed(rd_data2));
				writes_rd = 1'b1;
			end
			ADDI: begin
				result    = rd_data1 + imm_sext;
				writes_rd = 1'b1;
			end
			LUI: begin
				result    = {ins.imm, 16'h0000};
				writes_rd = 1'b1;
			end
			BEQZ:    branch_taken = (rd_data1 == '0);
			BNEZ:    branch_taken = (rd_data1 != '0);
			HALT:    is_halt = 1'b1;
			default: ;
		endcase
	end

	// writes to r0 are dropped here, so they never reach the writeback port.
	assign we      = take && writes_rd && (ins.rd != '0);
	assign wr_addr = ins.rd;
	assign wr_data = result;

	// the target wraps around the instruction memory.
	assign redirect    = take && branch_taken;
	assign redirect_pc = head.pc + pc_t'(1) + pc_t'(imm_sext);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_valid <= we;
			if (take && is_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (we) begin
			wb.rd   <= ins.rd;
			wb.data <= result;
		end
	end

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; (
	input  logic   CLK,
	input  logic   arst_n,
	input  logic   run,
	input  logic   hold,
	input  logic   prog_we,
	input  pc_t    prog_addr,
	input  instr_t prog_data,
	output logic   wb_valid,
	output wb_t    wb,
	output logic   halted
);

	logic       push;
	fetch_pkt_t pkt;
	logic       credit_return;
	logic       head_valid;
	fetch_pkt_t head;
	logic       take;
	logic       redirect;
	pc_t        redirect_pc;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	word_t      rd_data1;
	word_t      rd_data2;
	logic       we;
	reg_idx_t   wr_addr;
	word_t      wr_data;

	fetch_unit u_fetch (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.run           (run),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.credit_return (credit_return),
		.push          (push),
		.pkt           (pkt)
	);

	// a taken branch is the only source of a flush.
	fetch_queue u_queue (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.push          (push),
		.pkt           (pkt),
		.take          (take),
		.flush         (redirect),
		.head_valid    (head_valid),
		.head          (head),
		.credit_return (credit_return)
	);

	execute_unit u_execute (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.hold        (hold),
		.head_valid  (head_valid),
		.head        (head),
		.take        (take),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd_data1    (rd_data1),
		.rd_data2    (rd_data2),
		.we          (we),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_valid    (wb_valid),
		.wb          (wb),
		.halted      (halted)
	);

	register_file u_regs (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.we       (we),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

endmodule

// ==== test/cpu_sva.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_sva import cpu_pkg::*; (
	input logic    CLK,
	input logic    arst_n,
	input credit_t count,
	input logic    push,
	input credit_t credits,
	input logic    take,
	input logic    head_valid
);

	// the queue may be full but never holds more than its depth.
	a_occupancy: assert property (@(posedge CLK) disable iff (!arst_n)
		count <= `CPU_QUEUE_DEPTH)
		else $error("fetch queue occupancy is above its depth");

	// the credits mirror the free entries, so a push never meets a full queue.
	a_push_credit: assert property (@(posedge CLK) disable iff (!arst_n)
		push |-> count < credit_t'(`CPU_QUEUE_DEPTH))
		else $error("push arrived while the fetch unit had no credit left");

	a_credit_max: assert property (@(posedge CLK) disable iff (!arst_n)
		credits <= credit_t'(`CPU_QUEUE_DEPTH))
		else $error("fetch unit holds more credits than the queue has entries");

	a_take_valid: assert property (@(posedge CLK) disable iff (!arst_n)
		take |-> head_valid)
		else $error("execute unit took from an empty queue");

endmodule

// each instance checks the signals of its own block and ties the others inactive.
bind fetch_queue cpu_sva u_queue_sva (
	.CLK        (CLK),
	.arst_n     (arst_n),
	.count      (count),
	.push       (push),
	.credits    ('0),
	.take       (take),
	.head_valid (head_valid)
);

bind fetch_unit cpu_sva u_fetch_sva (
	.CLK        (CLK),
	.arst_n     (arst_n),
	.count      ('0),
	.push       (1'b0),
	.credits    (credits),
	.take       (1'b0),
	.head_valid (1'b1)
);

// ==== test/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int RUNS = 24;

	logic   CLK;
	logic   arst_n;
	logic   run;
	logic   hold = 1'b0;
	logic   prog_we;
	pc_t    prog_addr;
	instr_t prog_data;
	logic   wb_valid;
	wb_t    wb;
	logic   halted;

	instr_t      image [`CPU_IMEM_WORDS];
	int          prog_len;
	wb_t         exp_q [$];
	wb_t         exp_wb;
	string       test_name = "reset";
	int          hold_mode = 0;
	int          stretch_left = 0;
	logic        hold_seen = 1'b0;
	logic [31:0] prog_lfsr = 32'hc5fd_42dc;
	logic [31:0] hold_lfsr = 32'hc5fd_42dc;

	cpu_core u_dut (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.run       (run),
		.hold      (hold),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.halted    (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// right-shifting galois lfsr for x^32 + x^22 + x^2 + x + 1.
	function automatic logic lfsr_bit(inout logic [31:0] state);
		logic b;
		b = state[0];
		state = (state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
		return b;
	endfunction

	function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit(state)};
		end
		return v;
	endfunction

	function automatic void emit(opcode_t op, int rd, int rs1, int rs2, int imm);
		image[prog_len] = {op, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2), imm[15:0]};
		prog_len++;
	endfunction

	// words past the program are halts that carry their own address.
	function automatic void clear_image();
		for (int a = 0; a < `CPU_IMEM_WORDS; a++) begin
			image[a] = {HALT, 12'h000, 16'(a)};
		end
		prog_len = 0;
	endfunction

	function automatic void straight_program();
		clear_image();
		emit(ADDI, 1, 0, 0, 'h1234);
		emit(ADDI, 2, 0, 0, -3);
		emit(LUI, 3, 0, 0, 'h8000);
		emit(ADD, 4, 1, 2, 0);
		emit(SUB, 5, 2, 1, 0);
		emit(AND, 6, 1, 2, 0);
		emit(OR, 7, 3, 1, 0);
		emit(XOR, 8, 7, 2, 0);
		emit(SLT, 9, 3, 1, 0);
		emit(SLT, 10, 1, 3, 0);
		emit(ADDI, 0, 1, 0, 5);
		emit(ADD, 0, 1, 1, 0);
		emit(ADD, 11, 0, 4, 0);
		emit(NOP, 12, 1, 1, 0);
		emit(LUI, 13, 0, 0, 'hffff);
		emit(ADDI, 13, 13, 0, 'h7fff);
		emit(SUB, 14, 0, 13, 0);
		emit(HALT, 0, 0, 0, 0);
	endfunction

	function automatic void branch_program();
		clear_image();
		emit(ADDI, 1, 0, 0, 5);
		emit(BEQZ, 0, 1, 0, 2);
		emit(ADDI, 2, 0, 0, 7);
		// this branch is taken, and under long hold the writes behind it already wait in the queue.
		emit(BNEZ, 0, 1, 0, 2);
		emit(ADDI, 3, 0, 0, 99);
		emit(ADDI, 4, 0, 0, 99);
		emit(SUB, 5, 1, 1, 0);
		emit(BEQZ, 0, 5, 0, 3);
		emit(LUI, 6, 0, 0, 'hdead);
		emit(ADDI, 7, 0, 0, 1);
		emit(XOR, 8, 1, 2, 0);
		emit(BNEZ, 0, 5, 0, 4);
		emit(ADDI, 9, 2, 0, -1);
		emit(BEQZ, 0, 0, 0, 0);
		emit(OR, 10, 9, 1, 0);
		emit(HALT, 0, 0, 0, 0);
	endfunction

	function automatic void random_program();
		int         len;
		logic [3:0] op;
		int         rd;
		int         rs1;
		int         rs2;
		int         imm;
		clear_image();
		len = 16 + int'(lfsr_bits(prog_lfsr, 5));
		for (int i = 0; i < len - 1; i++) begin
			op = 4'(lfsr_bits(prog_lfsr, 4));
			// halt only closes the program and the unused encodings fold onto real ones.
			if (op == HALT) begin
				op = ADDI;
			end else if (op > NOP) begin
				op = op - 4'd8;
			end
			rd  = int'(lfsr_bits(prog_lfsr, 4));
			rs1 = int'(lfsr_bits(prog_lfsr, 4));
			rs2 = int'(lfsr_bits(prog_lfsr, 4));
			imm = int'(lfsr_bits(prog_lfsr, (op inside {BEQZ, BNEZ}) ? 3 : 16));
			emit(opcode_t'(op), rd, rs1, rs2, imm);
		end
		emit(HALT, 0, 0, 0, 0);
	endfunction

	// the instruction-set model lists every register write in program order.
	function automatic void build_expected();
		word_t  regs [`CPU_NUM_REGS];
		pc_t    pc;
		instr_t ins;
		word_t  a;
		word_t  b;
		word_t  imm;
		word_t  res;
		logic   stop;
		wb_t    e;
		exp_q.delete();
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		stop = 1'b0;
		for (int step = 0; step < `CPU_IMEM_WORDS && !stop; step++) begin
			ins = image[pc];
			a = regs[ins.rs1];
			b = regs[ins.rs2];
			imm = {{16{ins.imm[15]}}, ins.imm};
			pc = pc + pc_t'(1);
			case (ins.opcode)
				ADD:     res = a + b;
				SUB:     res = a - b;
				AND:     res = a & b;
				OR:      res = a | b;
				XOR:     res = a ^ b;
				SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				ADDI:    res = a + imm;
				LUI:     res = {ins.imm, 16'h0000};
				default: res = '0;
			endcase
			if ((ins.opcode == BEQZ && a == '0) || (ins.opcode == BNEZ && a != '0)) begin
				pc = pc + imm[`CPU_PC_W-1:0];
			end
			if (ins.opcode == HALT) begin
				stop = 1'b1;
			end else if (ins.opcode inside {ADD, SUB, AND, OR, XOR, SLT, ADDI, LUI}
				&& ins.rd != '0) begin
				regs[ins.rd] = res;
				e.rd = ins.rd;
				e.data = res;
				exp_q.push_back(e);
			end
		end
	endfunction

	task automatic fail_now(string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check(string what, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			fail_now($sformatf("** Error [%s] expected %h actual %h", what, expected, actual));
		end
	endtask

	always @(posedge CLK) begin
		hold_seen <= hold;
	end

	// DUT outputs move only at the rising edge, so they are settled here.
	always @(negedge CLK) begin
		if (arst_n && wb_valid) begin
			if (hold_seen) begin
				fail_now($sformatf("%s: writeback to r%0d while hold was high", test_name, wb.rd));
			end else if (halted) begin
				fail_now($sformatf("%s: writeback to r%0d after halted", test_name, wb.rd));
			end else if (exp_q.size() == 0) begin
				fail_now($sformatf("%s: more writebacks than the model expects", test_name));
			end else begin
				exp_wb = exp_q.pop_front();
				check($sformatf("%s writeback", test_name), 64'(exp_wb), 64'(wb));
			end
		end
	end

	always @(negedge CLK) begin
		if (hold_mode == 1) begin
			hold = lfsr_bit(hold_lfsr) & lfsr_bit(hold_lfsr);
		end else if (hold_mode == 2 && stretch_left > 0) begin
			stretch_left--;
		end else if (hold_mode == 2) begin
			hold = !hold;
			stretch_left = hold ? 8 + int'(lfsr_bits(hold_lfsr, 4)) : int'(lfsr_bits(hold_lfsr, 2));
		end else begin
			hold = 1'b0;
			stretch_left = 0;
		end
	end

	task automatic run_program(string name, int mode);
		test_name = name;
		@(negedge CLK);
		arst_n = 1'b0;
		run = 1'b0;
		repeat (2) @(negedge CLK);
		arst_n = 1'b1;
		build_expected();
		for (int a = 0; a < `CPU_IMEM_WORDS; a++) begin
			prog_we = 1'b1;
			prog_addr = pc_t'(a);
			prog_data = image[a];
			@(negedge CLK);
			check($sformatf("%s idle wb_valid", name), 64'd0, 64'(wb_valid));
			check($sformatf("%s idle halted", name), 64'd0, 64'(halted));
		end
		prog_we = 1'b0;
		@(posedge CLK);
		hold_mode = mode;
		@(negedge CLK);
		run = 1'b1;
		while (!halted) @(negedge CLK);
		repeat (4) @(negedge CLK);
		check($sformatf("%s writebacks missing", name), 64'd0, 64'(exp_q.size()));
		@(posedge CLK);
		hold_mode = 0;
		@(negedge CLK);
		run = 1'b0;
	endtask

	initial begin
		arst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		straight_program();
		run_program("straight", 0);
		branch_program();
		run_program("branch", 0);
		branch_program();
		run_program("branch hold", 2);
		straight_program();
		run_program("long hold", 2);
		for (int t = 0; t < 20; t++) begin
			random_program();
			run_program($sformatf("random %0d", t), 1);
		end
		$display("Test OK");
		$finish;
	end

	// four cycles for every memory word of every run.
	initial begin
		#(RUNS * `CPU_IMEM_WORDS * 4 * 10);
		fail_now("watchdog expired before all programs halted");
	end

endmodule

// ==== vlog.f ====
+incdir+include
source/cpu_pkg.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/register_file.sv
source/execute_unit.sv
source/cpu_core.sv
test/cpu_sva.sv
test/cpu_tb.sv

// ==== Makefile ====
TOP := cpu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
